//--- design/sd_spi_pkg.sv
////////////////////
// constants, command codes and state types for the SPI-mode memory card
// imported by every card module
////////////////////

`default_nettype none

package sd_spi_pkg;

    typedef logic [7:0] byte_t;    // one SPI byte, msb first on the wire

    localparam int NCR          = 4;      // fill bytes before R1
    localparam int SECTOR_BYTES = 512;
    localparam int BUF_ADDR_W   = 9;      // log2 of the sector size
    localparam int LBA_W        = 32;
    localparam int FRAME_LAST   = 5;      // byte_cnt once the CRC byte is in

    // first byte of a command frame, 01 start bits plus index
    typedef enum logic [7:0] {
        CMD_GO_IDLE     = 8'h40,    // CMD0
        CMD_SEND_OP     = 8'h41,    // CMD1
        CMD_IF_COND     = 8'h48,    // CMD8
        CMD_STATUS      = 8'h4d,    // CMD13
        CMD_BLOCKLEN    = 8'h50,    // CMD16
        CMD_READ_SINGLE = 8'h51,    // CMD17
        CMD_APP         = 8'h77,    // CMD55
        ACMD_OP_COND    = 8'h69,    // ACMD41
        CMD_READ_OCR    = 8'h7a,    // CMD58
        CMD_CRC_ONOFF   = 8'h7b     // CMD59
    } sd_cmd_e;

    typedef enum logic [7:0] {
        R1_READY   = 8'h00,
        R1_IDLE    = 8'h01,    // still in idle state
        R1_ILLEGAL = 8'h04,
        R1_PARAM   = 8'h40     // parameter error
    } r1_e;

    localparam byte_t DATA_TOKEN = 8'hfe;    // start of a single block

    // transmitter side of a block read
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_IO,    // waiting for the sector to land in the buffer
        RD_TOKEN,
        RD_DATA
    } rd_state_e;

    // bit 31 power-up done, bits 23..15 voltage window
    // bit 30 (card capacity) is filled in from allow_sdhc
    localparam logic [31:0] OCR_VOLT = 32'h80ff_8000;

endpackage

`default_nettype wire

//--- design/spi_shifter.sv
////////////////////
// samples the SPI clock on clk_sys and assembles bytes from sd_sdi
////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_shifter import sd_spi_pkg::*; (
    input  logic       clk_sys,
    input  logic       card_is_reset,
    input  logic       sd_cs,        // active low
    input  logic       sd_sck,
    input  logic       sd_sdi,
    output byte_t      rx_byte,
    output logic       rx_strobe,
    output logic       tx_strobe,
    output logic [2:0] bit_cnt
);

    logic       sck_q;    // sck one clk_sys ago
    logic       sck_rise;
    logic       sck_fall;
    logic [6:0] sbuf;     // first seven bits of the byte in progress

    assign sck_rise = ~sck_q & sd_sck;
    assign sck_fall = sck_q & ~sd_sck;

    // eighth bit is taken straight from the pin
    assign rx_byte   = {sbuf, sd_sdi};
    assign rx_strobe = sck_rise & ~sd_cs & (bit_cnt == 3'd7);

    // card changes sdo on falling edges, master samples on rising
    assign tx_strobe = sck_fall & ~sd_cs;

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            sck_q   <= 1'b0;
            bit_cnt <= 3'd0;
        end else begin
            sck_q <= sd_sck;
            if (sd_cs) begin
                bit_cnt <= 3'd0;    // deselect restarts byte alignment
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;    // wraps every byte
            end
        end
    end

    // shift register, msb first
    always_ff @(posedge clk_sys) begin
        if (sck_rise && !sd_cs) begin
            sbuf <= {sbuf[5:0], sd_sdi};
        end
    end

endmodule

`default_nettype wire

//--- design/cmd_decode.sv
////////////////////
// command framing on received bytes
// cmd_valid fires on the first fill byte after the CRC
////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmd_decode import sd_spi_pkg::*; (
    input  logic        clk_sys,
    input  logic        card_is_reset,
    input  logic        sd_cs,
    input  byte_t       rx_byte,
    input  logic        rx_strobe,
    input  logic [2:0]  reply_len,
    input  logic        read_active,
    output sd_cmd_e     cmd,
    output logic [31:0] arg,
    output logic [3:0]  byte_cnt,
    output logic        cmd_valid
);

    logic [3:0] reply_end;    // last byte_cnt still owned by the reply
    logic       new_cmd;

    // R1 slot plus any extra reply bytes behind it
    assign reply_end = 4'(FRAME_LAST + NCR) + {1'b0, reply_len};

    // start bits 01, reply done, no block transfer running
    assign new_cmd = rx_strobe && (rx_byte[7:6] == 2'b01) &&
                     (byte_cnt > reply_end) && !read_active;

    always_ff @(posedge clk_sys) begin
        if (card_is_reset || sd_cs) begin
            byte_cnt  <= 4'd15;    // parked, frame discarded
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= rx_strobe && (byte_cnt == 4'(FRAME_LAST));
            if (new_cmd) begin
                byte_cnt <= 4'd0;
            end else if (rx_strobe && byte_cnt != 4'd15) begin
                byte_cnt <= byte_cnt + 4'd1;    // saturates at 15
            end
        end
    end

    // command and argument, held until the next frame
    always_ff @(posedge clk_sys) begin
        if (new_cmd) begin
            cmd <= sd_cmd_e'(rx_byte);
        end
        if (rx_strobe) begin
            case (byte_cnt)
                4'd0: arg[31:24] <= rx_byte;
                4'd1: arg[23:16] <= rx_byte;
                4'd2: arg[15:8]  <= rx_byte;
                4'd3: arg[7:0]   <= rx_byte;
                default: ;    // CRC byte and fill ignored
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/cmd_execute.sv
////////////////////
// evaluates a received command into R1 and extra reply bytes
// and runs the sector request towards the I/O controller
////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmd_execute import sd_spi_pkg::*; (
    input  logic             clk_sys,
    input  logic             card_is_reset,
    input  logic             sd_cs,
    input  logic             allow_sdhc,
    input  sd_cmd_e          cmd,
    input  logic [31:0]      arg,
    input  logic             cmd_valid,
    input  logic             read_done,
    input  logic             sd_ack,
    output r1_e              r1,
    output byte_t            reply0,
    output byte_t            reply1,
    output byte_t            reply2,
    output byte_t            reply3,
    output logic [2:0]       reply_len,
    output logic             read_active,
    output logic             data_ready,
    output logic             sd_rd,
    output logic [LBA_W-1:0] sd_lba
);

    logic        idle_seen;    // CMD0 received since reset
    logic        app_cmd;      // last command was CMD55
    logic        ack_q;
    logic [31:0] ocr;
    r1_e         r1_n;
    byte_t       rep0_n;
    byte_t       rep1_n;
    byte_t       rep2_n;
    byte_t       rep3_n;
    logic [2:0]  len_n;
    logic        is_read;
    logic        is_app;

    assign ocr = OCR_VOLT | {1'b0, allow_sdhc, 30'd0};    // bit 30 high capacity

    // reply for the command in cmd/arg
    always_comb begin
        r1_n    = R1_ILLEGAL;    // unknown, or not yet reset
        rep0_n  = 8'h00;
        rep1_n  = 8'h00;
        rep2_n  = 8'h00;
        rep3_n  = 8'h00;
        len_n   = 3'd0;
        is_read = 1'b0;
        is_app  = 1'b0;
        if (cmd == CMD_GO_IDLE) begin
            r1_n = R1_IDLE;
        end else if (idle_seen) begin
            case (cmd)
                CMD_SEND_OP, CMD_CRC_ONOFF: r1_n = R1_READY;
                CMD_IF_COND: begin
                    r1_n   = R1_IDLE;
                    rep2_n = {4'h0, arg[11:8]};    // voltage accepted
                    rep3_n = arg[7:0];             // echo of check pattern
                    len_n  = 3'd4;
                end
                CMD_STATUS: begin
                    r1_n  = R1_READY;
                    len_n = 3'd1;    // R2, second byte all clear
                end
                CMD_BLOCKLEN: r1_n = (arg == SECTOR_BYTES) ? R1_READY : R1_PARAM;
                CMD_READ_SINGLE: begin
                    r1_n    = R1_READY;
                    is_read = 1'b1;
                end
                CMD_APP: begin
                    r1_n   = R1_IDLE;
                    is_app = 1'b1;
                end
                ACMD_OP_COND: begin
                    if (app_cmd) begin
                        r1_n = R1_READY;    // only valid as an app command
                    end
                end
                CMD_READ_OCR: begin
                    r1_n = R1_READY;
                    {rep0_n, rep1_n, rep2_n, rep3_n} = ocr;
                    len_n = 3'd4;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (card_is_reset) begin
            idle_seen   <= 1'b0;
            app_cmd     <= 1'b0;
            reply_len   <= 3'd0;
            read_active <= 1'b0;
            data_ready  <= 1'b0;
            sd_rd       <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            ack_q <= sd_ack;
            if (sd_rd && sd_ack) begin
                sd_rd <= 1'b0;    // controller took the request
            end
            if (ack_q && !sd_ack && read_active) begin
                data_ready <= 1'b1;    // end of ack, sector complete
            end
            if (read_done) begin
                read_active <= 1'b0;
                data_ready  <= 1'b0;
            end
            if (cmd_valid) begin
                reply_len <= len_n;
                app_cmd   <= is_app;
                if (cmd == CMD_GO_IDLE) begin
                    idle_seen <= 1'b1;
                end
                if (is_read) begin
                    read_active <= 1'b1;
                    sd_rd       <= 1'b1;
                end
            end
            if (sd_cs) begin    // deselect drops reply and read
                reply_len   <= 3'd0;
                read_active <= 1'b0;
                data_ready  <= 1'b0;
            end
        end
    end

    // reply bytes and block address, held as levels
    always_ff @(posedge clk_sys) begin
        if (cmd_valid) begin
            r1     <= r1_n;
            reply0 <= rep0_n;
            reply1 <= rep1_n;
            reply2 <= rep2_n;
            reply3 <= rep3_n;
            if (is_read) begin
                // byte address on standard capacity cards
                sd_lba <= allow_sdhc ? arg : (arg >> BUF_ADDR_W);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/reply_result.sv
////////////////////
// drives sd_sdo on falling sck edges with reply bytes, data token and sector data
////////////////////

`timescale 1ns/1ps
`default_nettype none

module reply_result import sd_spi_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  card_is_reset,
    input  logic                  sd_cs,
    input  logic                  tx_strobe,
    input  logic [2:0]            bit_cnt,
    input  logic [3:0]            byte_cnt,
    input  r1_e                   r1,
    input  byte_t                 reply0,
    input  byte_t                 reply1,
    input  byte_t                 reply2,
    input  byte_t                 reply3,
    input  logic [2:0]            reply_len,
    input  logic                  data_ready,
    input  byte_t                 buf_data,
    output logic [BUF_ADDR_W-1:0] buf_addr,
    output logic                  read_done,
    output logic                  sd_sdo
);

    rd_state_e rd_state;
    byte_t     slot_byte;    // reply byte owning the current byte_cnt
    logic      in_slot;
    logic      last_bit;     // last bit of a byte goes out on this strobe

    assign last_bit = (bit_cnt == 3'd7);

    // R1 sits NCR fill bytes behind the frame, extras follow it
    always_comb begin
        in_slot   = 1'b1;
        slot_byte = r1;
        if (byte_cnt == 4'(FRAME_LAST + NCR)) begin
            slot_byte = r1;
        end else if (reply_len > 3'd0 && byte_cnt == 4'(FRAME_LAST + NCR + 1)) begin
            slot_byte = reply0;
        end else if (reply_len > 3'd1 && byte_cnt == 4'(FRAME_LAST + NCR + 2)) begin
            slot_byte = reply1;
        end else if (reply_len > 3'd2 && byte_cnt == 4'(FRAME_LAST + NCR + 3)) begin
            slot_byte = reply2;
        end else if (reply_len > 3'd3 && byte_cnt == 4'(FRAME_LAST + NCR + 4)) begin
            slot_byte = reply3;
        end else begin
            in_slot = 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (card_is_reset || sd_cs) begin
            rd_state  <= RD_IDLE;
            buf_addr  <= '0;
            read_done <= 1'b0;
            sd_sdo    <= 1'b1;    // bus idles high
        end else begin
            read_done <= 1'b0;
            if (tx_strobe) begin
                sd_sdo <= in_slot ? slot_byte[~bit_cnt] : 1'b1;    // msb first
                case (rd_state)
                    RD_IDLE: begin
                        // arm once R1 is on its way out
                        if (last_bit && byte_cnt == 4'(FRAME_LAST + NCR)) begin
                            rd_state <= RD_WAIT_IO;
                        end
                    end
                    RD_WAIT_IO: begin
                        buf_addr <= '0;    // first data byte preloads
                        if (data_ready && last_bit && byte_cnt >= 4'(FRAME_LAST + NCR)) begin
                            rd_state <= RD_TOKEN;
                        end
                    end
                    RD_TOKEN: begin
                        sd_sdo <= DATA_TOKEN[~bit_cnt];
                        if (last_bit) begin
                            rd_state <= RD_DATA;
                        end
                    end
                    RD_DATA: begin
                        sd_sdo <= buf_data[~bit_cnt];
                        if (last_bit) begin
                            buf_addr <= buf_addr + 1'b1;    // next byte read ahead
                            if (buf_addr == BUF_ADDR_W'(SECTOR_BYTES - 1)) begin
                                rd_state  <= RD_IDLE;    // CRC bytes not sent
                                read_done <= 1'b1;
                            end
                        end
                    end
                    default: rd_state <= RD_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sector_buffer.sv
////////////////////
// one sector of RAM, filled by the I/O controller, read by the transmitter
////////////////////

`timescale 1ns/1ps
`default_nettype none

module sector_buffer import sd_spi_pkg::*; (
    input  logic                  clk_sys,
    input  logic [BUF_ADDR_W-1:0] wr_addr,
    input  byte_t                 wr_data,
    input  logic                  wr_en,
    input  logic [BUF_ADDR_W-1:0] rd_addr,
    output byte_t                 rd_data
);

    byte_t mem [SECTOR_BYTES];

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one clk_sys of latency
    always_ff @(posedge clk_sys) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- design/sd_card_spi.sv
////////////////////
// SPI-mode memory card, sector reads served by a host I/O controller
////////////////////

`timescale 1ns/1ps
`default_nettype none

module sd_card_spi import sd_spi_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  card_is_reset,
    input  logic                  sd_cs,
    input  logic                  sd_sck,
    input  logic                  sd_sdi,
    output logic                  sd_sdo,
    input  logic                  allow_sdhc,      // block addressed card
    output logic [LBA_W-1:0]      sd_lba,
    output logic                  sd_rd,
    input  logic                  sd_ack,
    input  logic [BUF_ADDR_W-1:0] sd_buff_addr,
    input  byte_t                 sd_buff_dout,
    input  logic                  sd_buff_wr
);

    byte_t                 rx_byte;
    logic                  rx_strobe;
    logic                  tx_strobe;
    logic [2:0]            bit_cnt;
    sd_cmd_e               cmd;
    logic [31:0]           arg;
    logic [3:0]            byte_cnt;
    logic                  cmd_valid;
    r1_e                   r1;
    byte_t                 reply0;
    byte_t                 reply1;
    byte_t                 reply2;
    byte_t                 reply3;
    logic [2:0]            reply_len;
    logic                  read_active;
    logic                  data_ready;
    logic                  read_done;
    logic [BUF_ADDR_W-1:0] buf_addr;
    byte_t                 buf_data;

    // port names match the nets above
    spi_shifter  u_shifter (.*);
    cmd_decode   u_decode  (.*);
    cmd_execute  u_execute (.*);
    reply_result u_result  (.*);

    // only reads exist, controller writes go straight in
    sector_buffer u_buffer (
        .clk_sys (clk_sys),
        .wr_addr (sd_buff_addr),
        .wr_data (sd_buff_dout),
        .wr_en   (sd_buff_wr),
        .rd_addr (buf_addr),
        .rd_data (buf_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_sd_card_spi.sv
////////////////////
// testbench for the SPI-mode card: SPI master, I/O controller model, reference replies
// run with build.f, top module tb_sd_card_spi
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_sd_card_spi import sd_spi_pkg::*; ();

    localparam int NFILL    = 10;    // fill bytes after each frame, covers R1 plus 4 extras
    localparam int SCAN_MAX = 40;    // fill bytes allowed before the data token
    localparam int N_CMDS   = 15;
    localparam int N_READS  = 2;
    localparam int READ_BYTES = 6 + NCR + 1 + SCAN_MAX + SECTOR_BYTES;
    // 64 clk_sys per byte at sck = clk_sys/8
    localparam int TIMEOUT_CYCLES =
        (N_CMDS * (6 + NFILL) + 3 + N_READS * READ_BYTES) * 64 + N_READS * 4000;

    logic                  clk_sys;
    logic                  card_is_reset;
    logic                  sd_cs;
    logic                  sd_sck;
    logic                  sd_sdi;
    logic                  sd_sdo;
    logic                  allow_sdhc;
    logic [LBA_W-1:0]      sd_lba;
    logic                  sd_rd;
    logic                  sd_ack;
    logic [BUF_ADDR_W-1:0] sd_buff_addr;
    byte_t                 sd_buff_dout;
    logic                  sd_buff_wr;

    logic        model_idle;     // CMD0 seen by the card model
    logic        model_app;      // CMD55 armed
    byte_t       ctrl_data [SECTOR_BYTES];    // sector as written by the controller
    logic [31:0] lba_seen;
    int          rd_seen = 0;
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];
    string       what_q [$];
    string       cur_test = "reset";
    int          test_errs = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          checks = 0;
    int          cycles = 0;
    int          rnd_init;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_got;
    string       cmp_what;

    sd_card_spi dut (.*);

    initial clk_sys = 1'b0;
    always #20 clk_sys = ~clk_sys;    // 40 ns

    // expected fill bytes 1..NFILL, fill 1 in the low byte
    function automatic logic [8*NFILL-1:0] expect_reply(input byte_t c, input logic [31:0] a,
                                                      input logic idle, input logic app,
                                                      input logic sdhc);
        logic [8*NFILL-1:0] r;
        byte_t              r1v;
        logic [31:0]        ext;    // extra bytes, first one on top
        int                 n;
        int                 i;
        r   = '1;         // idle bus reads all ones
        r1v = 8'h04;      // illegal by default
        ext = 32'd0;
        n   = 0;
        if (c == 8'h40) begin
            r1v = 8'h01;    // CMD0 always accepted
        end else if (idle) begin
            case (c)
                8'h41, 8'h51, 8'h7b: r1v = 8'h00;    // CMD1, CMD17, CMD59
                8'h48: begin    // CMD8 echoes voltage and pattern
                    r1v = 8'h01;
                    ext = {16'd0, 4'd0, a[11:8], a[7:0]};
                    n   = 4;
                end
                8'h4d: begin
                    r1v = 8'h00;
                    n   = 1;
                end
                8'h50: r1v = (a == 32'd512) ? 8'h00 : 8'h40;
                8'h77: r1v = 8'h01;
                8'h69: r1v = app ? 8'h00 : 8'h04;
                8'h7a: begin    // OCR: powered up, capacity bit, 2.7..3.6 V
                    r1v = 8'h00;
                    ext = {1'b1, sdhc, 6'd0, 9'h1ff, 15'd0};
                    n   = 4;
                end
                default: r1v = 8'h04;
            endcase
        end
        r[8*NCR +: 8] = r1v;    // R1 in fill 5
        for (i = 0; i < n; i++) begin
            r[8*(NCR+1+i) +: 8] = ext[31-8*i -: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] expect_lba(input logic [31:0] a, input logic sdhc);
        return sdhc ? a : {9'd0, a[31:9]};    // byte address on standard capacity
    endfunction

    task automatic wait_clk(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    // one SPI byte, mode 0, sdo sampled just before each rising sck
    task automatic xfer_byte(input byte_t tx, output byte_t rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            sd_sdi = tx[i];
            wait_clk(4);
            rx[i]  = sd_sdo;
            sd_sck = 1'b1;
            wait_clk(4);
            sd_sck = 1'b0;
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] e, input logic [31:0] g);
        exp_q.push_back(e);
        what_q.push_back(what);
        got_q.push_back(g);
    endtask

    task automatic send_frame(input byte_t c, input logic [31:0] a);
        byte_t rx;
        xfer_byte(c, rx);
        xfer_byte(a[31:24], rx);
        xfer_byte(a[23:16], rx);
        xfer_byte(a[15:8], rx);
        xfer_byte(a[7:0], rx);
        xfer_byte(8'h95, rx);    // CRC, valid for CMD0 only, card ignores it
    endtask

    task automatic update_model(input byte_t c);
        model_app = model_idle && (c == 8'h77);    // any other command disarms
        if (c == 8'h40) begin
            model_idle = 1'b1;
        end
    endtask

    task automatic run_cmd(input byte_t c, input logic [31:0] a);
        logic [8*NFILL-1:0] e;
        byte_t              rx;
        int                 i;
        e = expect_reply(c, a, model_idle, model_app, allow_sdhc);
        send_frame(c, a);
        for (i = 0; i < NFILL; i++) begin
            xfer_byte(8'hff, rx);
            check_val($sformatf("cmd %h fill %0d", c, i + 1), e[8*i +: 8], rx);
        end
        update_model(c);
    endtask

    task automatic run_read(input logic [31:0] a);
        logic [8*NFILL-1:0] e;
        byte_t              rx;
        int                 i;
        int                 n;
        int                 rd_before;
        logic               found;
        e = expect_reply(8'h51, a, model_idle, model_app, allow_sdhc);
        rd_before = rd_seen;
        send_frame(8'h51, a);
        for (i = 0; i <= NCR; i++) begin    // up to and including R1
            xfer_byte(8'hff, rx);
            check_val($sformatf("read fill %0d", i + 1), e[8*i +: 8], rx);
        end
        update_model(8'h51);
        found = 1'b0;
        n = 0;
        while (!found && n < SCAN_MAX) begin    // latency set by the controller
            xfer_byte(8'hff, rx);
            n++;
            found = (rx != 8'hff);
        end
        assert (found) else begin
            $display("%s: no data token within %0d bytes after R1", cur_test, SCAN_MAX);
            test_errs++;
        end
        assert (rd_seen == rd_before + 1) else begin
            $display("%s: card never raised sd_rd", cur_test);
            test_errs++;
        end
        check_val("sd_lba", expect_lba(a, allow_sdhc), lba_seen);
        if (found) begin
            check_val("token", DATA_TOKEN, rx);
            for (i = 0; i < SECTOR_BYTES; i++) begin
                xfer_byte(8'hff, rx);
                check_val($sformatf("data[%0d]", i), ctrl_data[i], rx);
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test;
        while (got_q.size() != 0) begin
            wait_clk(1);    // let the compare process drain
        end
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errs);
        end
    endtask

    // compares one queued value per clock
    always @(posedge clk_sys) begin
        if (got_q.size() > 0) begin
            cmp_exp  = exp_q.pop_front();
            cmp_got  = got_q.pop_front();
            cmp_what = what_q.pop_front();
            checks++;
            assert (cmp_got === cmp_exp) else begin
                $display("mismatch %s %s: expected %h, actual %h",
                         cur_test, cmp_what, cmp_exp, cmp_got);
                test_errs++;
            end
        end
    end

    // I/O controller, answers sd_rd after a random delay
    initial begin : io_controller
        int          delay;
        int          i;
        logic [31:0] rnd;
        forever begin
            wait_clk(1);
            if (sd_rd === 1'b1 && sd_ack == 1'b0) begin
                lba_seen = sd_lba;
                rd_seen++;
                delay = $urandom_range(200, 10);
                wait_clk(delay);
                sd_ack = 1'b1;
                for (i = 0; i < SECTOR_BYTES; i++) begin
                    rnd          = $urandom;
                    ctrl_data[i] = rnd[7:0];
                    sd_buff_addr = i[BUF_ADDR_W-1:0];
                    sd_buff_dout = rnd[7:0];
                    sd_buff_wr   = 1'b1;
                    wait_clk(1);
                end
                sd_buff_wr = 1'b0;
                sd_ack     = 1'b0;    // falling ack, sector complete
            end
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] arg;
        byte_t       rx;
        int          s;
        rnd_init      = $urandom(32'he497c604);
        card_is_reset = 1'b1;
        sd_cs         = 1'b1;
        sd_sck        = 1'b0;
        sd_sdi        = 1'b1;
        allow_sdhc    = 1'b1;
        sd_ack        = 1'b0;
        sd_buff_addr  = '0;
        sd_buff_dout  = 8'h00;
        sd_buff_wr    = 1'b0;
        model_idle    = 1'b0;
        model_app     = 1'b0;
        wait_clk(2);
        card_is_reset = 1'b0;
        wait_clk(2);
        sd_cs = 1'b0;
        wait_clk(2);

        start_test("go_idle");
        run_cmd(8'h7a, 32'd0);    // CMD58 before CMD0
        run_cmd(8'h40, 32'd0);
        end_test();

        start_test("if_cond");
        arg = $urandom;
        run_cmd(8'h48, arg);
        end_test();

        start_test("blocklen_status");
        run_cmd(8'h50, 32'd512);
        arg = $urandom;
        if (arg == 32'd512) begin
            arg = 32'd513;
        end
        run_cmd(8'h50, arg);
        run_cmd(8'h4d, 32'd0);
        end_test();

        for (s = 1; s >= 0; s--) begin
            allow_sdhc = s[0];
            start_test($sformatf("app_ocr_sdhc%0d", s));
            run_cmd(8'h69, 32'h4000_0000);    // no CMD55 before it
            run_cmd(8'h77, 32'd0);
            run_cmd(8'h69, 32'h4000_0000);
            run_cmd(8'h7a, 32'd0);
            end_test();
        end

        for (s = 1; s >= 0; s--) begin
            allow_sdhc = s[0];
            start_test($sformatf("read_sdhc%0d", s));
            arg = $urandom;
            run_read(arg);
            end_test();
        end

        start_test("cs_abort");
        xfer_byte(8'h48, rx);    // half a CMD8 frame
        xfer_byte(8'h00, rx);
        xfer_byte(8'h01, rx);
        sd_cs = 1'b1;
        wait_clk(4);
        sd_cs = 1'b0;
        wait_clk(2);
        run_cmd(8'h40, 32'd0);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/sd_spi_pkg.sv
design/spi_shifter.sv
design/cmd_decode.sv
design/cmd_execute.sv
design/reply_result.sv
design/sector_buffer.sv
design/sd_card_spi.sv
verif/tb_sd_card_spi.sv

//--- Bender.yml
package:
  name: sd_card_spi

sources:
  - design/sd_spi_pkg.sv
  - design/spi_shifter.sv
  - design/cmd_decode.sv
  - design/cmd_execute.sv
  - design/reply_result.sv
  - design/sector_buffer.sv
  - design/sd_card_spi.sv
  - target: simulation
    files:
      - verif/tb_sd_card_spi.sv
